// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Mdir obj_dir
TOP       = tb_sm_manager
FILELIST  = filelist.f
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/sm_testdata.txt
// One fetch per line as wwwww_c_p_j_ppp_s_eee in hex
// word, control_jump, busy_poll, jump_cycle, jump_ptr, segment, expected pointer
00a31_0_0_0_000_0_040
01234_0_1_0_000_0_041
2fe07_0_0_0_000_0_042
00055_0_1_0_000_0_043
1205a_1_0_0_000_0_044 // control jump to 120
3c0c0_0_0_0_000_0_120
00008_0_0_1_2a0_3_121 // enable_lo bit 3 set
000f7_0_0_1_2a0_3_2a0 // enable_lo bit 3 clear, hold
01000_0_0_1_155_b_2a0 // enable_hi bit 3 set
3ef08_0_0_1_0aa_b_155 // enable_hi bit 3 clear, hold
30000_1_0_1_2ee_0_155 // control jump ignored in a mailbox cycle
30000_1_0_1_0c3_f_155 // enable_hi bit 7 set
0ffff_0_1_0_000_0_0c3
3ff11_1_0_0_000_0_0c4 // control jump to 3ff
15555_0_0_0_000_0_3ff // increment wraps
2aaaa_0_0_0_000_0_000

// File: bench/tb_sm_manager.sv
// Self-checking testbench for the sensor manager sequencer
// Replays the step data file through a register bus slave model and checks the pointer

`timescale 1ns/1ps

`include "sm_consts.svh"

module tb_sm_manager
    import sm_word_pkg::*;
    import sm_ctrl_pkg::*;
();

    // --------------------
    // Run length
    // --------------------

    localparam int       num_steps   = 16;
    // Longest fetch, write and poll round trip in cycles
    localparam int       step_max    = `SM_ACK_WAIT_MAX + `SM_BUSY_WAIT_MAX + 6;
    // Reset, idle checks and run drop tail on top of the steps
    localparam int       cycle_limit = num_steps * step_max + 40;
    localparam sm_addr_t start_addr  = 10'h040;

    logic            CLK_IN;
    logic            RESET_IN;
    logic            run;
    sm_addr_t        runtime_addr;
    logic            control_jump;
    sm_instr_word_u  instr_word;
    sm_mailbox_t     mbox;
    sm_bus_rsp_t     bus_rsp;
    sm_bus_req_t     bus_req;
    logic            read_select;
    sm_addr_t        instr_ptr;
    logic            busy;

    // Packed hex fields with the word at the top and the expected pointer at the bottom
    logic [59:0]     step_mem [0:num_steps-1];

    integer          seed;
    int              errors;
    int              tests_run;
    int              tests_bad;
    int              test_err_base;
    int              cycle_count;
    string           test_name;

    sm_manager_top sm_manager_top_inst (
        .CLK_IN       (CLK_IN),
        .RESET_IN     (RESET_IN),
        .run          (run),
        .runtime_addr (runtime_addr),
        .control_jump (control_jump),
        .instr_word   (instr_word),
        .mbox         (mbox),
        .bus_rsp      (bus_rsp),
        .bus_req      (bus_req),
        .read_select  (read_select),
        .instr_ptr    (instr_ptr),
        .busy         (busy)
    );

    // 10 ns clock
    initial
    begin
        CLK_IN = 1'b0;
        forever #5 CLK_IN = ~CLK_IN;
    end

    // Watchdog on a cycle count
    initial
    begin
        cycle_count = 0;
        while (cycle_count < cycle_limit)
        begin
            @(posedge CLK_IN);
            cycle_count++;
        end
        $display("Timeout: sequencer made no progress within %0d cycles", cycle_count);
        $display("Test failed");
        $finish;
    end

    // --------------------
    // Helpers
    // --------------------

    // Inputs change and outputs are sampled 1 ns after the edge
    task automatic next_cycle();
        @(posedge CLK_IN);
        #1;
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("[FAIL] %s %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        test_err_base = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err_base)
        begin
            $display("test %s: ok", test_name);
        end
        else
        begin
            tests_bad++;
            $display("test %s: %0d mismatches", test_name, errors - test_err_base);
        end
    endtask

    task automatic wait_read_select();
        while (read_select !== 1'b1)
            next_cycle();
    endtask

    // Decode flags and mailbox fields held until the next fetch
    task automatic load_step(input logic [59:0] entry);
        instr_word         = entry[57:40];
        control_jump       = entry[36];
        bus_rsp.busy_poll  = entry[32];
        mbox.jump_cycle    = entry[28];
        mbox.jump_ptr      = entry[25:16];
        mbox.segment       = entry[15:12];
    endtask

    // Register target, random ack delay and random busy pulse
    task automatic serve_write(input logic poll);
        int ack_delay;
        int busy_time;

        ack_delay = $unsigned($random(seed)) % `SM_ACK_WAIT_MAX;
        busy_time = 1 + $unsigned($random(seed)) % `SM_BUSY_WAIT_MAX;
        while (bus_req.stb !== 1'b1)
            next_cycle();
        check_value("write strobes", 7, int'(bus_req));
        // Back-pressure
        repeat (ack_delay)
        begin
            next_cycle();
            check_value("bus_req held", 7, int'(bus_req));
        end
        bus_rsp.ack = 1'b1;
        next_cycle();
        bus_rsp.ack = 1'b0;
        check_value("bus_req after ack", 0, int'(bus_req));
        check_value("busy while running", 1, int'(busy));
        if (poll)
        begin
            next_cycle();
            bus_rsp.busy = 1'b1;
            repeat (busy_time)
            begin
                next_cycle();
                check_value("read_select while target busy", 0, int'(read_select));
            end
            bus_rsp.busy = 1'b0;
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial
    begin
        seed          = 5875;
        errors        = 0;
        tests_run     = 0;
        tests_bad     = 0;
        test_err_base = 0;
        test_name     = "setup";
        RESET_IN      = 1'b1;
        run           = 1'b0;
        runtime_addr  = start_addr;
        control_jump  = 1'b0;
        instr_word    = '0;
        mbox          = '0;
        bus_rsp       = '0;
        $readmemh("bench/sm_testdata.txt", step_mem);

        repeat (16) @(posedge CLK_IN);
        #1;
        RESET_IN = 1'b0;

        // Quiet outputs with run low
        begin_test("reset_idle");
        repeat (3)
        begin
            next_cycle();
            check_value("bus_req", 0, int'(bus_req));
            check_value("read_select", 0, int'(read_select));
            check_value("busy", 0, int'(busy));
            check_value("instr_ptr", 0, int'(instr_ptr));
        end
        end_test();

        // Busy at once and first fetch one edge later
        begin_test("run_start");
        run = 1'b1;
        next_cycle();
        check_value("busy", 1, int'(busy));
        check_value("read_select early", 0, int'(read_select));
        next_cycle();
        check_value("read_select", 1, int'(read_select));
        check_value("instr_ptr", int'(start_addr), int'(instr_ptr));
        end_test();

        // One file line per fetch
        for (int i = 0; i < num_steps; i++)
        begin
            begin_test($sformatf("step_%02d", i));
            if (i > 0)
                wait_read_select();
            check_value("instr_ptr", int'(step_mem[i][9:0]), int'(instr_ptr));
            load_step(step_mem[i]);
            if (i < num_steps - 1)
                serve_write(step_mem[i][32]);
            end_test();
        end

        // Last write abandoned with ack present on the same edge
        begin_test("run_drop");
        while (bus_req.stb !== 1'b1)
            next_cycle();
        next_cycle();
        run         = 1'b0;
        bus_rsp.ack = 1'b1;
        next_cycle();
        bus_rsp.ack = 1'b0;
        check_value("bus_req", 0, int'(bus_req));
        check_value("busy", 0, int'(busy));
        repeat (8)
        begin
            next_cycle();
            check_value("read_select", 0, int'(read_select));
            check_value("busy", 0, int'(busy));
            check_value("instr_ptr", int'(step_mem[num_steps-1][9:0]), int'(instr_ptr));
        end
        end_test();

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
                 tests_run, tests_run - tests_bad, tests_bad, errors);
        if (errors == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+logic
logic/sm_word_pkg.sv
logic/sm_ctrl_pkg.sv
logic/sm_sequencer.sv
logic/sm_instr_ptr.sv
logic/sm_manager_top.sv
bench/tb_sm_manager.sv

// File: logic/sm_consts.svh
// Shared widths, reset pointer and slave wait bounds for the sensor manager
// Include wherever one of these values is needed

`ifndef SM_CONSTS_SVH
`define SM_CONSTS_SVH

// --------------------
// Widths
// --------------------

// Instruction pointer into sensor memory
`define SM_ADDR_W 10

// Sensor memory word
`define SM_WORD_W 18

// Mailbox segment counter, picks one of 16 enable bits
`define SM_SEG_W 4

// --------------------
// Reset values and limits
// --------------------

// Pointer value out of reset
`define SM_INIT_PTR 0

// Longest ack delay and busy time a target may take, in clock cycles
`define SM_ACK_WAIT_MAX 8
`define SM_BUSY_WAIT_MAX 12

`endif

// File: logic/sm_ctrl_pkg.sv
// Control side types of the sensor manager
// FSM states, register bus request and response, mailbox fields and pointer commands

package sm_ctrl_pkg;

`include "sm_consts.svh"

    import sm_word_pkg::*;

    // --------------------
    // Sequencer states
    // --------------------

    // Codes 3 and 5 are left unused
    typedef enum logic [2:0] {
        sm_idle          = 3'd0,
        sm_inc_ptr       = 3'd1,
        sm_inst_rd       = 3'd2,
        sm_reg_wr        = 3'd4,
        sm_wait_busy_on  = 3'd6,
        sm_wait_busy_off = 3'd7
    } sm_state_e;

    // --------------------
    // Register bus
    // --------------------

    // Write strobes held together until ack
    typedef struct packed {
        logic  we;
        logic  stb;
        logic  cyc;
    } sm_bus_req_t;

    // Target side ack, busy level and the per-register poll request
    typedef struct packed {
        logic  ack;
        logic  busy;
        logic  busy_poll;
    } sm_bus_rsp_t;

    // --------------------
    // Pointer control
    // --------------------

    // Mailbox jump fields from the mailbox block
    typedef struct packed {
        logic                   jump_cycle;
        sm_addr_t               jump_ptr;
        logic [`SM_SEG_W-1:0]   segment;
    } sm_mailbox_t;

    // One cycle pulses with at most one high at a time
    typedef struct packed {
        logic  start;
        logic  advance;
        logic  step;
    } sm_ptr_cmd_t;

endpackage

// File: logic/sm_instr_ptr.sv
// Instruction pointer of the sensor manager; applies the sequencer's commands
// and picks increment, control jump, mailbox jump or hold

`timescale 1ns/1ps

`include "sm_consts.svh"

module sm_instr_ptr
    import sm_word_pkg::*;
    import sm_ctrl_pkg::*;
(
    input  logic            CLK_IN,
    input  logic            RESET_IN,
    input  sm_ptr_cmd_t     ptr_cmd,
    input  sm_addr_t        runtime_addr,
    input  logic            control_jump,
    input  sm_instr_word_u  instr_word,
    input  sm_mailbox_t     mbox,
    output sm_addr_t        instr_ptr
);

    sm_addr_t  ptr_nxt;
    logic      mbox_en;

    // --------------------
    // Mailbox enable select
    // --------------------

    // Top segment bit picks the half, the rest picks the bit in it
    always_comb
    begin
        if (mbox.segment[`SM_SEG_W-1])
            mbox_en = instr_word.mbox.enable_hi[mbox.segment[`SM_SEG_W-2:0]];
        else
            mbox_en = instr_word.mbox.enable_lo[mbox.segment[`SM_SEG_W-2:0]];
    end

    // --------------------
    // Next pointer
    // --------------------

    always_comb
    begin
        ptr_nxt = instr_ptr;

        if (ptr_cmd.start)
        begin
            ptr_nxt = runtime_addr;
        end
        else if (ptr_cmd.step)
        begin
            ptr_nxt = instr_ptr + sm_addr_t'(1);
        end
        else if (ptr_cmd.advance)
        begin
            // Mailbox jump wins over the control jump
            if (mbox.jump_cycle && mbox_en)
                ptr_nxt = mbox.jump_ptr;
            else if (control_jump && !mbox.jump_cycle)
                ptr_nxt = instr_word.jump.jump_addr;
            else if (mbox.jump_cycle)
                ptr_nxt = instr_ptr;    // mailbox bit clear, stay put
            else
                ptr_nxt = instr_ptr + sm_addr_t'(1);
        end
    end

    always_ff @(posedge CLK_IN or posedge RESET_IN)
    begin
        if (RESET_IN)
            instr_ptr <= sm_addr_t'(`SM_INIT_PTR);
        else
            instr_ptr <= ptr_nxt;
    end

    // Pointer only moves one edge after a command pulse
    a_ptr_moves_on_cmd: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
        !$stable(instr_ptr) |-> $past(|ptr_cmd));

endmodule

// File: logic/sm_manager_top.sv
// Sensor manager instruction sequencer, top level
// Joins the control FSM and the pointer block to the outside ports

`timescale 1ns/1ps

module sm_manager_top
    import sm_word_pkg::*;
    import sm_ctrl_pkg::*;
(
    input  logic            CLK_IN,
    input  logic            RESET_IN,
    input  logic            run,
    input  sm_addr_t        runtime_addr,
    input  logic            control_jump,
    input  sm_instr_word_u  instr_word,
    input  sm_mailbox_t     mbox,
    input  sm_bus_rsp_t     bus_rsp,
    output sm_bus_req_t     bus_req,
    output logic            read_select,
    output sm_addr_t        instr_ptr,
    output logic            busy
);

    // Sequencer to pointer commands
    sm_ptr_cmd_t  ptr_cmd;

    // --------------------
    // Control FSM
    // --------------------

    sm_sequencer sm_sequencer_inst (
        .CLK_IN      (CLK_IN),
        .RESET_IN    (RESET_IN),
        .run         (run),
        .bus_rsp     (bus_rsp),
        .bus_req     (bus_req),
        .read_select (read_select),
        .busy        (busy),
        .ptr_cmd     (ptr_cmd)
    );

    // --------------------
    // Instruction pointer
    // --------------------

    sm_instr_ptr sm_instr_ptr_inst (
        .CLK_IN       (CLK_IN),
        .RESET_IN     (RESET_IN),
        .ptr_cmd      (ptr_cmd),
        .runtime_addr (runtime_addr),
        .control_jump (control_jump),
        .instr_word   (instr_word),
        .mbox         (mbox),
        .instr_ptr    (instr_ptr)
    );

endmodule

// File: logic/sm_sequencer.sv
// Control FSM of the sensor manager; fetches each instruction, writes it
// over the register bus and tells the pointer block when to move

`timescale 1ns/1ps

module sm_sequencer
    import sm_ctrl_pkg::*;
(
    input  logic         CLK_IN,
    input  logic         RESET_IN,
    input  logic         run,
    input  sm_bus_rsp_t  bus_rsp,
    output sm_bus_req_t  bus_req,
    output logic         read_select,
    output logic         busy,
    output sm_ptr_cmd_t  ptr_cmd
);

    // --------------------
    // State and next values
    // --------------------

    sm_state_e    state;
    sm_state_e    state_nxt;

    // All outputs are registered, each has a next value
    sm_bus_req_t  bus_req_nxt;
    logic         read_select_nxt;
    logic         busy_nxt;
    sm_ptr_cmd_t  ptr_cmd_nxt;

    always_ff @(posedge CLK_IN or posedge RESET_IN)
    begin
        if (RESET_IN)
        begin
            state       <= sm_idle;
            bus_req     <= '0;
            read_select <= 1'b0;
            busy        <= 1'b0;
            ptr_cmd     <= '0;
        end
        else
        begin
            state       <= state_nxt;
            bus_req     <= bus_req_nxt;
            read_select <= read_select_nxt;
            busy        <= busy_nxt;
            ptr_cmd     <= ptr_cmd_nxt;
        end
    end

    // --------------------
    // Next state logic
    // --------------------

    always_comb
    begin
        // Defaults: strobes low, no pulses, busy while running
        state_nxt       = state;
        bus_req_nxt     = '0;
        read_select_nxt = 1'b0;
        busy_nxt        = 1'b1;
        ptr_cmd_nxt     = '0;

        case (state)
            sm_idle:
            begin
                if (run)
                begin
                    // Load the run-time start address
                    state_nxt         = sm_inc_ptr;
                    ptr_cmd_nxt.start = 1'b1;
                end
                else
                begin
                    busy_nxt = 1'b0;
                end
            end

            sm_inc_ptr:
            begin
                // Pointer has settled, ask memory for the word
                state_nxt       = sm_inst_rd;
                read_select_nxt = 1'b1;
            end

            sm_inst_rd:
            begin
                // Word is on the bus, open the write
                state_nxt   = sm_reg_wr;
                bus_req_nxt = '{we: 1'b1, stb: 1'b1, cyc: 1'b1};
            end

            sm_reg_wr:
            begin
                if (!run)
                begin
                    // Run dropped, abandon the write even if ack is here
                    state_nxt = sm_idle;
                    busy_nxt  = 1'b0;
                end
                else if (!bus_rsp.ack)
                begin
                    // Back-pressure just stretches the write
                    bus_req_nxt = '{we: 1'b1, stb: 1'b1, cyc: 1'b1};
                end
                else if (bus_rsp.busy_poll)
                begin
                    // Target needs time, wait for its busy pulse
                    state_nxt = sm_wait_busy_on;
                end
                else
                begin
                    state_nxt           = sm_inc_ptr;
                    ptr_cmd_nxt.advance = 1'b1;
                end
            end

            sm_wait_busy_on:
            begin
                if (bus_rsp.busy)
                begin
                    state_nxt = sm_wait_busy_off;
                end
            end

            sm_wait_busy_off:
            begin
                // Transfer done, plain increment
                if (!bus_rsp.busy)
                begin
                    state_nxt        = sm_inc_ptr;
                    ptr_cmd_nxt.step = 1'b1;
                end
            end

            default:
            begin
                state_nxt = sm_idle;
                busy_nxt  = 1'b0;
            end
        endcase
    end

    // --------------------
    // Checks
    // --------------------

    // Strobe never goes out without a cycle around it
    a_stb_in_cyc: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
        bus_req.stb |-> bus_req.cyc);

    // Pointer block sees one command at a time
    a_one_ptr_cmd: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
        $onehot0(ptr_cmd));

    // Fetch and register write never overlap
    a_rd_not_wr: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
        !(read_select && bus_req.stb));

endmodule

// File: logic/sm_word_pkg.sv
// Memory side types of the sensor manager: instruction address and the
// two decodings of one sensor memory word

package sm_word_pkg;

`include "sm_consts.svh"

    // Instruction address into sensor memory
    typedef logic [`SM_ADDR_W-1:0] sm_addr_t;

    // --------------------
    // Jump decoding
    // --------------------

    // Upper bits carry the branch target, the rest is the register operand
    typedef struct packed {
        sm_addr_t                          jump_addr;
        logic [`SM_WORD_W-`SM_ADDR_W-1:0]  operand;
    } sm_jump_view_t;

    // --------------------
    // Mailbox decoding
    // --------------------

    // Sixteen enable bits split by a spare bit at position 8
    typedef struct packed {
        logic        spare_hi;
        logic [7:0]  enable_hi;
        logic        spare_mid;
        logic [7:0]  enable_lo;
    } sm_mbox_view_t;

    // Same word seen both ways
    typedef union packed {
        sm_jump_view_t  jump;
        sm_mbox_view_t  mbox;
    } sm_instr_word_u;

endpackage
